// ==== design/rename_params.svh ====
/*
  Widths and sizes for the register rename stage
  Group width, commit width, architectural and physical register files
*/
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Micro-ops renamed per cycle
`define RENAME_WIDTH 2

// Commit reports accepted per cycle
`define COMMIT_WIDTH 2

// Architectural integer registers
`define ARCH_REGS 32
`define ARCH_INDEX_SIZE 5

// Physical integer registers
`define PRF_SIZE 64
`define PRF_INDEX_SIZE 6

// Free counter holds 0 to PRF_SIZE inclusive
`define FREE_COUNT_SIZE 7

`endif

// ==== design/rename_pkg.sv ====
/*
  Shared types of the rename stage
  Register index types and micro-op kinds
*/
`include "rename_params.svh"

package rename_pkg;

  // Architectural register index
  typedef logic [`ARCH_INDEX_SIZE-1:0] arch_reg_t;

  // Physical register index
  typedef logic [`PRF_INDEX_SIZE-1:0] phys_reg_t;

  // Micro-op kind
  // only alu and load write a destination register
  typedef enum logic [1:0] {
    kind_alu    = 2'd0,
    kind_load   = 2'd1,
    kind_store  = 2'd2,
    kind_branch = 2'd3
  } uop_kind_e;

endpackage

// ==== design/free_list.sv ====
/*
  Physical register free list
  Speculative and recovery busy bitmaps, lowest-first allocation
*/
`include "rename_params.svh"

module free_list (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         recover,
  input  logic                                         stall,
  input  logic                  [`COMMIT_WIDTH-1:0]    commit_valid,
  input  rename_pkg::phys_reg_t [`COMMIT_WIDTH-1:0]    commit_prd,
  input  rename_pkg::phys_reg_t [`COMMIT_WIDTH-1:0]    commit_old_prd,
  input  logic                  [`RENAME_WIDTH-1:0]    alloc_req,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]    alloc_prd,
  output logic                                         allocatable
);

  import rename_pkg::*;

  localparam logic [`PRF_SIZE-1:0] RESET_BUSY =
    {{(`PRF_SIZE - `ARCH_REGS){1'b0}}, {`ARCH_REGS{1'b1}}};
  localparam logic [`FREE_COUNT_SIZE-1:0] RESET_FREE = `PRF_SIZE - `ARCH_REGS;

  // Bit set means busy
  logic [`PRF_SIZE-1:0]        spec_busy;
  logic [`FREE_COUNT_SIZE-1:0] spec_count;
  logic [`PRF_SIZE-1:0]        rec_busy;

  logic [`PRF_SIZE-1:0]        freed_busy;
  logic [`FREE_COUNT_SIZE-1:0] freed_count;
  logic [`PRF_SIZE-1:0]        rec_busy_next;
  logic [`PRF_SIZE-1:0]        alloc_busy;
  logic [`FREE_COUNT_SIZE-1:0] req_count;

  // Commit frees are visible to allocation this cycle
  always_comb begin
    freed_busy     = spec_busy;
    freed_count    = spec_count;
    rec_busy_next  = rec_busy;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      if (commit_valid[i]) begin
        freed_busy[commit_old_prd[i]]    = 1'b0;
        freed_count                      = freed_count + 1'b1;
        rec_busy_next[commit_old_prd[i]] = 1'b0;
        rec_busy_next[commit_prd[i]]     = 1'b1;
      end
    end
  end

  always_comb begin
    req_count = '0;
    for (int s = 0; s < `RENAME_WIDTH; s++) begin
      if (alloc_req[s]) begin
        req_count = req_count + 1'b1;
      end
    end
  end

  assign allocatable = (req_count <= freed_count);

  // Lowest free register per requesting slot in slot order
  always_comb begin : pick
    logic found;
    alloc_busy = freed_busy;
    for (int s = 0; s < `RENAME_WIDTH; s++) begin
      alloc_prd[s] = '0;
      found = 1'b0;
      if (alloc_req[s]) begin
        for (int p = 0; p < `PRF_SIZE; p++) begin
          if (!found && !alloc_busy[p]) begin
            alloc_prd[s] = phys_reg_t'(p);
            found = 1'b1;
          end
        end
        if (found) begin
          alloc_busy[alloc_prd[s]] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      spec_busy  <= RESET_BUSY;
      spec_count <= RESET_FREE;
      rec_busy   <= RESET_BUSY;
    end else begin
      rec_busy <= rec_busy_next;
      if (recover) begin
        // Commit point always maps ARCH_REGS registers
        spec_busy  <= rec_busy_next;
        spec_count <= RESET_FREE;
      end else if (stall) begin
        // Commits still free registers while stalled
        spec_busy  <= freed_busy;
        spec_count <= freed_count;
      end else begin
        spec_busy  <= alloc_busy;
        spec_count <= freed_count - req_count;
      end
    end
  end

endmodule

// ==== design/map_table.sv ====
/*
  Register alias tables
  Speculative map with in-group bypass, committed map for recovery
*/
`include "rename_params.svh"

module map_table (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         recover,
  input  rename_pkg::arch_reg_t [`RENAME_WIDTH-1:0]    rs1,
  input  rename_pkg::arch_reg_t [`RENAME_WIDTH-1:0]    rs2,
  input  rename_pkg::arch_reg_t [`RENAME_WIDTH-1:0]    rd,
  input  logic                  [`RENAME_WIDTH-1:0]    write_en,
  input  rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]    write_prd,
  input  logic                  [`COMMIT_WIDTH-1:0]    commit_valid,
  input  rename_pkg::arch_reg_t [`COMMIT_WIDTH-1:0]    commit_rd,
  input  rename_pkg::phys_reg_t [`COMMIT_WIDTH-1:0]    commit_prd,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]    prs1,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]    prs2,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]    old_prd
);

  import rename_pkg::*;

  phys_reg_t spec_map   [`ARCH_REGS];
  phys_reg_t commit_map [`ARCH_REGS];
  phys_reg_t spec_next  [`ARCH_REGS];
  phys_reg_t commit_next[`ARCH_REGS];

  // Later slots see earlier slots' new destinations
  always_comb begin
    for (int s = 0; s < `RENAME_WIDTH; s++) begin
      prs1[s]    = spec_map[rs1[s]];
      prs2[s]    = spec_map[rs2[s]];
      old_prd[s] = spec_map[rd[s]];
      for (int j = 0; j < s; j++) begin
        if (write_en[j] && rd[j] == rs1[s]) begin
          prs1[s] = write_prd[j];
        end
        if (write_en[j] && rd[j] == rs2[s]) begin
          prs2[s] = write_prd[j];
        end
        if (write_en[j] && rd[j] == rd[s]) begin
          old_prd[s] = write_prd[j];
        end
      end
    end
  end

  // Last writer of a register wins
  always_comb begin
    spec_next = spec_map;
    for (int s = 0; s < `RENAME_WIDTH; s++) begin
      if (write_en[s]) begin
        spec_next[rd[s]] = write_prd[s];
      end
    end
  end

  always_comb begin
    commit_next = commit_map;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      if (commit_valid[i]) begin
        commit_next[commit_rd[i]] = commit_prd[i];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // Identity mapping out of reset
      for (int i = 0; i < `ARCH_REGS; i++) begin
        spec_map[i]   <= phys_reg_t'(i);
        commit_map[i] <= phys_reg_t'(i);
      end
    end else begin
      commit_map <= commit_next;
      if (recover) begin
        spec_map <= commit_next;
      end else begin
        spec_map <= spec_next;
      end
    end
  end

endmodule

// ==== design/rename_unit.sv ====
/*
  Rename control and output stage
  Input handshake, destination requests, output register with back-pressure
*/
`include "rename_params.svh"

module rename_unit (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         recover,
  input  logic                                         in_valid,
  output logic                                         in_ready,
  input  logic                  [`RENAME_WIDTH-1:0]    in_slot_valid,
  input  rename_pkg::uop_kind_e [`RENAME_WIDTH-1:0]    in_kind,
  input  rename_pkg::arch_reg_t [`RENAME_WIDTH-1:0]    in_rd,
  output logic                                         out_valid,
  input  logic                                         out_ready,
  output logic                  [`RENAME_WIDTH-1:0]    out_slot_valid,
  output rename_pkg::uop_kind_e [`RENAME_WIDTH-1:0]    out_kind,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]    out_prd,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]    out_prs1,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]    out_prs2,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]    out_old_prd,
  input  logic                                         allocatable,
  input  rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]    alloc_prd,
  input  rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]    prs1,
  input  rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]    prs2,
  input  rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]    old_prd,
  output logic                  [`RENAME_WIDTH-1:0]    alloc_req,
  output logic                                         stall,
  output logic                  [`RENAME_WIDTH-1:0]    write_en
);

  import rename_pkg::*;

  logic [`RENAME_WIDTH-1:0] need_rd;
  logic                     accept;
  logic                     active;

  // Writes to x0 take no register
  always_comb begin
    for (int s = 0; s < `RENAME_WIDTH; s++) begin
      need_rd[s] = in_slot_valid[s] && in_rd[s] != '0 &&
                   (in_kind[s] == kind_alu || in_kind[s] == kind_load);
    end
  end

  assign alloc_req = need_rd & {`RENAME_WIDTH{in_valid}};
  assign in_ready  = active && allocatable && !recover && (!out_valid || out_ready);
  assign accept    = in_valid && in_ready;
  assign stall     = !accept;
  assign write_en  = need_rd & {`RENAME_WIDTH{accept}};

  // Opens the input one cycle after reset
  always_ff @(posedge clock) begin
    if (reset) begin
      active <= 1'b0;
    end else begin
      active <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || recover) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Payload loads only on accept
  always_ff @(posedge clock) begin
    if (accept) begin
      out_slot_valid <= in_slot_valid;
      out_kind       <= in_kind;
      out_prs1       <= prs1;
      out_prs2       <= prs2;
      for (int s = 0; s < `RENAME_WIDTH; s++) begin
        out_prd[s]     <= need_rd[s] ? alloc_prd[s] : phys_reg_t'(0);
        out_old_prd[s] <= need_rd[s] ? old_prd[s] : phys_reg_t'(0);
      end
    end
  end

endmodule

// ==== design/rename_top.sv ====
/*
  Rename stage top level
  Connects control unit, map table and free list
*/
`include "rename_params.svh"

module rename_top (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         recover,
  input  logic                                         in_valid,
  output logic                                         in_ready,
  input  logic                  [`RENAME_WIDTH-1:0]    in_slot_valid,
  input  rename_pkg::uop_kind_e [`RENAME_WIDTH-1:0]    in_kind,
  input  rename_pkg::arch_reg_t [`RENAME_WIDTH-1:0]    in_rd,
  input  rename_pkg::arch_reg_t [`RENAME_WIDTH-1:0]    in_rs1,
  input  rename_pkg::arch_reg_t [`RENAME_WIDTH-1:0]    in_rs2,
  output logic                                         out_valid,
  input  logic                                         out_ready,
  output logic                  [`RENAME_WIDTH-1:0]    out_slot_valid,
  output rename_pkg::uop_kind_e [`RENAME_WIDTH-1:0]    out_kind,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]    out_prd,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]    out_prs1,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]    out_prs2,
  output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]    out_old_prd,
  input  logic                  [`COMMIT_WIDTH-1:0]    commit_valid,
  input  rename_pkg::arch_reg_t [`COMMIT_WIDTH-1:0]    commit_rd,
  input  rename_pkg::phys_reg_t [`COMMIT_WIDTH-1:0]    commit_prd,
  input  rename_pkg::phys_reg_t [`COMMIT_WIDTH-1:0]    commit_old_prd
);

  import rename_pkg::*;

  logic                                      allocatable;
  logic                                      stall;
  logic      [`RENAME_WIDTH-1:0]             alloc_req;
  logic      [`RENAME_WIDTH-1:0]             write_en;
  phys_reg_t [`RENAME_WIDTH-1:0]             alloc_prd;
  phys_reg_t [`RENAME_WIDTH-1:0]             prs1;
  phys_reg_t [`RENAME_WIDTH-1:0]             prs2;
  phys_reg_t [`RENAME_WIDTH-1:0]             old_prd;

  rename_unit unit (
    .clock, .reset, .recover,
    .in_valid, .in_ready, .in_slot_valid, .in_kind, .in_rd,
    .out_valid, .out_ready, .out_slot_valid, .out_kind,
    .out_prd, .out_prs1, .out_prs2, .out_old_prd,
    .allocatable, .alloc_prd, .prs1, .prs2, .old_prd,
    .alloc_req, .stall, .write_en
  );

  map_table maps (
    .clock, .reset, .recover,
    .rs1(in_rs1), .rs2(in_rs2), .rd(in_rd),
    .write_en, .write_prd(alloc_prd),
    .commit_valid, .commit_rd, .commit_prd,
    .prs1, .prs2, .old_prd
  );

  free_list frees (
    .clock, .reset, .recover, .stall,
    .commit_valid, .commit_prd, .commit_old_prd,
    .alloc_req, .alloc_prd, .allocatable
  );

endmodule

// ==== testbench/rename_asserts.sv ====
/*
  Concurrent checks on the rename stage
  Reset state, output hold under back-pressure, recover blocking input
*/
`include "rename_params.svh"

module rename_asserts (
  input logic                                      clock,
  input logic                                      reset,
  input logic                                      recover,
  input logic                                      in_ready,
  input logic                                      out_valid,
  input logic                                      out_ready,
  input logic                  [`RENAME_WIDTH-1:0] out_slot_valid,
  input rename_pkg::uop_kind_e [`RENAME_WIDTH-1:0] out_kind,
  input rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] out_prd,
  input rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] out_prs1,
  input rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] out_prs2,
  input rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] out_old_prd
);

  import rename_pkg::*;

  // Number of failed checks
  int fail_count = 0;

  reset_clears_out: assert property (@(posedge clock) reset |=> !out_valid)
    else begin
      fail_count++;
      $error("out_valid high after a reset cycle");
    end

  // Held group may not change until taken
  hold_stable: assert property (@(posedge clock)
    (out_valid && !out_ready && !reset && !recover) |=>
      (out_valid && $stable(out_slot_valid) && $stable(out_kind) && $stable(out_prd) &&
       $stable(out_prs1) && $stable(out_prs2) && $stable(out_old_prd)))
    else begin
      fail_count++;
      $error("output group changed while stalled");
    end

  recover_blocks_input: assert property (@(posedge clock) recover |-> !in_ready)
    else begin
      fail_count++;
      $error("in_ready high during recover");
    end

endmodule

// ==== testbench/rename_tb.sv ====
/*
  Testbench for the rename stage
  LCG stimulus, reference model, output comparison
*/
`include "rename_params.svh"

module rename_tb;

  import rename_pkg::*;

  typedef struct packed {
    logic      [`RENAME_WIDTH-1:0] sv;
    uop_kind_e [`RENAME_WIDTH-1:0] kind;
    arch_reg_t [`RENAME_WIDTH-1:0] rd;
    arch_reg_t [`RENAME_WIDTH-1:0] rs1;
    arch_reg_t [`RENAME_WIDTH-1:0] rs2;
  } in_group_t;

  typedef struct packed {
    logic      [`RENAME_WIDTH-1:0] need;
    logic      [`RENAME_WIDTH-1:0] sv;
    uop_kind_e [`RENAME_WIDTH-1:0] kind;
    phys_reg_t [`RENAME_WIDTH-1:0] prd;
    phys_reg_t [`RENAME_WIDTH-1:0] prs1;
    phys_reg_t [`RENAME_WIDTH-1:0] prs2;
    phys_reg_t [`RENAME_WIDTH-1:0] old;
  } group_t;

  typedef struct packed {
    arch_reg_t rd;
    phys_reg_t prd;
    phys_reg_t old;
  } dest_t;

  logic clock, reset, recover, in_valid, in_ready, out_valid, out_ready;
  logic      [`RENAME_WIDTH-1:0] in_slot_valid, out_slot_valid;
  uop_kind_e [`RENAME_WIDTH-1:0] in_kind, out_kind;
  arch_reg_t [`RENAME_WIDTH-1:0] in_rd, in_rs1, in_rs2;
  phys_reg_t [`RENAME_WIDTH-1:0] out_prd, out_prs1, out_prs2, out_old_prd;
  logic      [`COMMIT_WIDTH-1:0] commit_valid;
  arch_reg_t [`COMMIT_WIDTH-1:0] commit_rd;
  phys_reg_t [`COMMIT_WIDTH-1:0] commit_prd, commit_old_prd;

  // Model state
  phys_reg_t          m_spec [`ARCH_REGS];
  phys_reg_t          m_commit [`ARCH_REGS];
  logic [`PRF_SIZE-1:0] m_busy, m_rec;

  group_t    expected[$];
  dest_t     outstanding[$];
  in_group_t directed[$];
  int unsigned lcg_state = 71;
  int accepted_count = 0;
  int ready_pct, recover_pct;
  logic commit_on, random_on, alu_only, force_recover, holding, m_out_valid;

  rename_top uut (.*);

  bind rename_top rename_asserts checks (
    .clock, .reset, .recover, .in_ready, .out_valid, .out_ready,
    .out_slot_valid, .out_kind, .out_prd, .out_prs1, .out_prs2, .out_old_prd
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  task fail_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task check_phys(input string name, input phys_reg_t got, input phys_reg_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task check_kind(input string name, input uop_kind_e got, input uop_kind_e exp);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  // Expected group and allocatable from a copy of the model state
  function automatic logic rename_ref(output group_t e);
    logic [`PRF_SIZE-1:0] busy;
    int free_n;
    int req_n;
    logic found;
    busy = m_busy;
    free_n = 0;
    req_n = 0;
    e = '0;
    for (int c = 0; c < `COMMIT_WIDTH; c++) begin
      if (commit_valid[c]) begin
        busy[commit_old_prd[c]] = 1'b0;
      end
    end
    for (int p = 0; p < `PRF_SIZE; p++) begin
      free_n += !busy[p];
    end
    for (int s = 0; s < `RENAME_WIDTH; s++) begin
      e.need[s] = in_valid && in_slot_valid[s] && in_rd[s] != 0 &&
                  (in_kind[s] == kind_alu || in_kind[s] == kind_load);
      req_n += e.need[s];
      e.sv[s] = in_slot_valid[s];
      e.kind[s] = in_kind[s];
      e.prs1[s] = m_spec[in_rs1[s]];
      e.prs2[s] = m_spec[in_rs2[s]];
      if (s > 0 && e.need[0] && in_rd[0] == in_rs1[s]) e.prs1[s] = e.prd[0];
      if (s > 0 && e.need[0] && in_rd[0] == in_rs2[s]) e.prs2[s] = e.prd[0];
      if (e.need[s]) begin
        e.old[s] = (s > 0 && e.need[0] && in_rd[0] == in_rd[s]) ? e.prd[0] : m_spec[in_rd[s]];
        found = 1'b0;
        for (int p = 0; p < `PRF_SIZE; p++) begin
          if (!found && !busy[p]) begin
            e.prd[s] = phys_reg_t'(p);
            found = 1'b1;
          end
        end
        busy[e.prd[s]] = 1'b1;
      end
    end
    return req_n <= free_n;
  endfunction

  task add_group(input logic [1:0] sv, input uop_kind_e k0, input uop_kind_e k1,
                 input int rd0, input int rd1, input int a0, input int a1,
                 input int b0, input int b1);
    in_group_t g;
    g.sv = sv;
    g.kind = {k1, k0};
    g.rd = {arch_reg_t'(rd1), arch_reg_t'(rd0)};
    g.rs1 = {arch_reg_t'(a1), arch_reg_t'(a0)};
    g.rs2 = {arch_reg_t'(b1), arch_reg_t'(b0)};
    directed.push_back(g);
  endtask

  // Drive one cycle, then model, check and update at mid-cycle
  task step();
    in_group_t g;
    group_t e;
    dest_t d;
    logic alloc_ok, accept;
    int n;
    @(posedge clock);
    #1;
    recover = force_recover || (recover_pct > 0 && lcg_next() % 100 < recover_pct);
    force_recover = 1'b0;
    out_ready = !recover && (lcg_next() % 100 < ready_pct);
    commit_valid = '0;
    n = commit_on ? lcg_next() % 3 : 0;
    for (int c = 0; c < n; c++) begin
      if (outstanding.size() > 0) begin
        d = outstanding.pop_front();
        commit_valid[c] = 1'b1;
        commit_rd[c] = d.rd;
        commit_prd[c] = d.prd;
        commit_old_prd[c] = d.old;
      end
    end
    if (!holding) begin
      in_valid = 1'b0;
      if (directed.size() > 0) begin
        g = directed.pop_front();
        in_valid = 1'b1;
      end else if (random_on) begin
        g.sv = 2'(lcg_next());
        if (g.sv == 0) g.sv = 2'b11;
        for (int s = 0; s < `RENAME_WIDTH; s++) begin
          g.kind[s] = alu_only ? kind_alu : uop_kind_e'(lcg_next());
          g.rd[s] = alu_only ? arch_reg_t'(1 + lcg_next() % 31) : arch_reg_t'(lcg_next());
          g.rs1[s] = arch_reg_t'(lcg_next());
          g.rs2[s] = arch_reg_t'(lcg_next());
        end
        in_valid = 1'b1;
      end
      if (in_valid) begin
        in_slot_valid = g.sv;
        in_kind = g.kind;
        in_rd = g.rd;
        in_rs1 = g.rs1;
        in_rs2 = g.rs2;
      end
    end
    @(negedge clock);
    check_bit("out_valid", out_valid, m_out_valid);
    alloc_ok = rename_ref(e);
    accept = alloc_ok && !recover && (!m_out_valid || out_ready);
    check_bit("in_ready", in_ready, accept);
    accept = accept && in_valid;
    holding = in_valid && !accept;
    if (recover) begin
      m_out_valid = 1'b0;
    end else if (accept) begin
      m_out_valid = 1'b1;
    end else if (out_ready) begin
      m_out_valid = 1'b0;
    end
    for (int c = 0; c < `COMMIT_WIDTH; c++) begin
      if (commit_valid[c]) begin
        m_commit[commit_rd[c]] = commit_prd[c];
        m_rec[commit_old_prd[c]] = 1'b0;
        m_rec[commit_prd[c]] = 1'b1;
        m_busy[commit_old_prd[c]] = 1'b0;
      end
    end
    if (recover) begin
      m_spec = m_commit;
      m_busy = m_rec;
      expected.delete();
      outstanding.delete();
    end else if (accept) begin
      for (int s = 0; s < `RENAME_WIDTH; s++) begin
        if (e.need[s]) begin
          m_busy[e.prd[s]] = 1'b1;
          m_spec[in_rd[s]] = e.prd[s];
          outstanding.push_back('{in_rd[s], e.prd[s], e.old[s]});
        end
      end
      expected.push_back(e);
      accepted_count++;
    end
  endtask

  task run_groups(input int more, input string what);
    int target;
    int cycles;
    target = accepted_count + more;
    cycles = 0;
    while (accepted_count < target) begin
      step();
      cycles++;
      if (cycles > 20000) fail_run({"timeout waiting for groups to be accepted: ", what});
    end
  endtask

  task run_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      step();
    end
  endtask

  task drain();
    int cycles;
    random_on = 1'b0;
    ready_pct = 100;
    recover_pct = 0;
    cycles = 0;
    while (expected.size() > 0 || holding || out_valid) begin
      step();
      cycles++;
      if (cycles > 200) fail_run("timeout waiting for the output to drain");
    end
  endtask

  always @(uut.checks.fail_count) begin
    if (uut.checks.fail_count != 0) begin
      fail_run("a concurrent assertion on the DUT failed");
    end
  end

  // Output transfers against the expected queue
  always @(negedge clock) begin
    group_t e;
    if (!reset && out_valid && out_ready) begin
      if (expected.size() == 0) begin
        fail_run("an output group was transferred that was never expected");
      end else begin
        e = expected.pop_front();
        for (int s = 0; s < `RENAME_WIDTH; s++) begin
          check_bit($sformatf("out_slot_valid[%0d]", s), out_slot_valid[s], e.sv[s]);
          check_kind($sformatf("out_kind[%0d]", s), out_kind[s], e.kind[s]);
          check_phys($sformatf("out_prd[%0d]", s), out_prd[s], e.prd[s]);
          check_phys($sformatf("out_prs1[%0d]", s), out_prs1[s], e.prs1[s]);
          check_phys($sformatf("out_prs2[%0d]", s), out_prs2[s], e.prs2[s]);
          check_phys($sformatf("out_old_prd[%0d]", s), out_old_prd[s], e.old[s]);
        end
      end
    end
  end

  initial begin
    reset = 1'b1;
    recover = 1'b0;
    in_valid = 1'b0;
    out_ready = 1'b0;
    in_slot_valid = '0;
    in_kind = {kind_alu, kind_alu};
    in_rd = '0;
    in_rs1 = '0;
    in_rs2 = '0;
    commit_valid = '0;
    commit_rd = '0;
    commit_prd = '0;
    commit_old_prd = '0;
    {commit_on, random_on, alu_only, force_recover, holding, m_out_valid} = '0;
    ready_pct = 100;
    recover_pct = 0;
    for (int i = 0; i < `ARCH_REGS; i++) begin
      m_spec[i] = phys_reg_t'(i);
      m_commit[i] = phys_reg_t'(i);
    end
    m_busy = {{(`PRF_SIZE - `ARCH_REGS){1'b0}}, {`ARCH_REGS{1'b1}}};
    m_rec = m_busy;
    repeat (8) @(posedge clock);
    #1 reset = 1'b0;

    // First group after reset
    ready_pct = 0;
    add_group(2'b11, kind_alu, kind_alu, 5, 6, 1, 2, 3, 4);
    run_groups(1, "first group");
    step();
    check_bit("out_valid", out_valid, 1'b1);
    check_phys("out_prd[0]", out_prd[0], 32);
    check_phys("out_prd[1]", out_prd[1], 33);
    check_phys("out_old_prd[0]", out_old_prd[0], 5);
    check_phys("out_old_prd[1]", out_old_prd[1], 6);
    ready_pct = 100;

    // Bypass, then kinds and x0 that take no register
    add_group(2'b11, kind_alu, kind_alu, 7, 7, 1, 7, 2, 7);
    add_group(2'b11, kind_store, kind_branch, 9, 10, 7, 5, 6, 9);
    add_group(2'b11, kind_alu, kind_load, 0, 0, 7, 0, 6, 7);
    run_groups(3, "directed groups");

    // Exhaustion, then frees by commit
    random_on = 1'b1;
    alu_only = 1'b1;
    run_cycles(30);
    check_bit("in_ready", in_ready, 1'b0);
    commit_on = 1'b1;
    run_groups(20, "groups after commits resumed");
    alu_only = 1'b0;

    ready_pct = 50;
    run_groups(40, "groups under back-pressure");

    force_recover = 1'b1;
    run_cycles(2);
    run_groups(20, "groups after recover");

    ready_pct = 70;
    recover_pct = 2;
    run_groups(400, "long random run");
    drain();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+design
design/rename_pkg.sv
design/free_list.sv
design/map_table.sv
design/rename_unit.sv
design/rename_top.sv
testbench/rename_asserts.sv
testbench/rename_tb.sv
